//--- hdl/cpu_isa_pkg.sv
// TLCS-900H instruction set definitions
package cpu_isa_pkg;

    // ALU operation codes
    typedef enum logic [5:0] {
        ALU_NOP,
        ALU_MOVE,
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_OR,
        ALU_CP,
        ALU_CPL,
        ALU_CCF,
        ALU_CHG,
        ALU_BIT,
        ALU_BS1F,
        ALU_BS1B,
        ALU_EXTS,
        ALU_EXTZ,
        ALU_MDEC1,
        ALU_MDEC2,
        ALU_MDEC4
    } alu_op_t;

    typedef logic [7:0] reg_code_t;   // full register code

    // opcode byte split for decoding, grp and zz together form the high nibble
    typedef struct packed {
        logic [23:0] upper;   // bytes 3..1
        logic [1:0]  grp;
        logic [1:0]  zz;      // operand size
        logic        sel;
        logic [2:0]  rrr;     // short register field
    } op_fields_t;

    // little-endian fetch window, byte 0 is the opcode
    typedef union packed {
        logic [3:0][7:0] bytes;
        op_fields_t      fields;
    } op_word_u;

    // high nibbles of the current bank register codes
    localparam logic [3:0] REG_BASE_E = 4'he;
    localparam logic [3:0] REG_BASE_F = 4'hf;

endpackage

//--- hdl/ctrl_phase_pkg.sv
// Sequencer control codes
package ctrl_phase_pkg;

    typedef enum logic [2:0] {
        FETCH    = 3'd0,
        EXEC     = 3'd1,
        FILL_IMM = 3'd2,
        DUMMY    = 3'd3
    } phase_t;

    typedef logic [1:0] size_t;
    localparam size_t SZ_BYTE = 2'd0;
    localparam size_t SZ_WORD = 2'd1;
    localparam size_t SZ_LONG = 2'd2;
    localparam size_t SZ_JP24 = 2'd3;   // 24-bit jump target

    typedef logic [2:0] we_mask_t;      // one-hot byte/word/long

    typedef enum logic [1:0] {
        IMM_HOLD,
        IMM_LOAD_BYTE1,
        IMM_LOAD_NIBBLE,
        IMM_LOAD_RRR
    } imm_act_t;

    typedef enum logic [1:0] {DST_HOLD, DST_SHORT, DST_BYTE1} dst_sel_t;
    typedef enum logic [1:0] {SRC_HOLD, SRC_NEW_DST, SRC_OLD_DST} src_sel_t;

endpackage

//--- hdl/ctrl_fsm.sv
// Sequencer phase control
`timescale 1ns/1ps

module ctrl_fsm import cpu_isa_pkg::*, ctrl_phase_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       op_ok,
    input  logic [1:0] dec_fetched,
    input  phase_t     dec_phase,
    input  size_t      dec_size,
    input  logic       dec_size_we,
    input  we_mask_t   dec_we,
    input  we_mask_t   dec_keep_we,
    input  logic       dec_keep_pc,
    input  logic       dec_flag_we,
    input  logic       dec_rfp_we,
    input  logic       dec_inc_rfp,
    input  logic       dec_dec_rfp,
    input  logic       dec_nodummy,
    input  alu_op_t    dec_alu_op,
    input  logic       dec_alu_smux,
    input  logic       dec_alu_wait,
    output phase_t     phase,
    output size_t      op_zz,
    output logic       ram_wait,
    output logic       fill,
    output logic [1:0] fetched,
    output logic       pc_we,
    output we_mask_t   regs_we,
    output logic       flag_we,
    output logic       rfp_we,
    output logic       inc_rfp,
    output logic       dec_rfp,
    output alu_op_t    alu_op,
    output logic       alu_smux,
    output logic       alu_wait
);

    logic     stall;      // refill cycle after a consuming cycle
    logic     advance;
    logic     replay;     // phases that issue the held write
    we_mask_t keep_we;
    logic     keep_pc;
    logic     nodummy;

    // no usable bytes this cycle
    assign ram_wait = stall | ~op_ok;
    assign advance  = ~ram_wait;
    assign replay   = (phase == FILL_IMM) || (phase == DUMMY);
    assign fill     = advance && (phase == FILL_IMM);

    // a dummy after a short immediate op reuses no byte
    assign fetched = (phase == DUMMY && nodummy) ? 2'd0 : dec_fetched;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= FETCH;
            op_zz    <= SZ_BYTE;
            stall    <= 1'b0;
            keep_we  <= '0;
            keep_pc  <= 1'b0;
            nodummy  <= 1'b0;
            regs_we  <= '0;
            pc_we    <= 1'b0;
            flag_we  <= 1'b0;
            rfp_we   <= 1'b0;
            inc_rfp  <= 1'b0;
            dec_rfp  <= 1'b0;
            alu_op   <= ALU_NOP;
            alu_smux <= 1'b0;
            alu_wait <= 1'b0;
        end else if (cen) begin
            stall   <= fetched != 2'd0;
            regs_we <= '0;       // strobes last one cycle
            pc_we   <= 1'b0;
            flag_we <= 1'b0;
            rfp_we  <= 1'b0;
            inc_rfp <= 1'b0;
            dec_rfp <= 1'b0;
            if (advance) begin
                phase    <= dec_phase;
                nodummy  <= dec_nodummy;
                alu_wait <= dec_alu_wait;
                flag_we  <= dec_flag_we;
                rfp_we   <= dec_rfp_we;
                inc_rfp  <= dec_inc_rfp;
                dec_rfp  <= dec_dec_rfp;
                if (dec_size_we) begin
                    op_zz <= dec_size;
                end
                if (replay) begin
                    regs_we <= keep_we;  // alu op stays from the first byte
                    pc_we   <= keep_pc;
                end else begin
                    regs_we  <= dec_we;
                    keep_we  <= dec_keep_we;
                    keep_pc  <= dec_keep_pc;
                    alu_op   <= dec_alu_op;
                    alu_smux <= dec_alu_smux;
                end
            end
        end
    end

endmodule

//--- hdl/op_decoder.sv
// Opcode decoder
`timescale 1ns/1ps

module op_decoder import cpu_isa_pkg::*, ctrl_phase_pkg::*; (
    input  op_word_u   op,
    input  phase_t     phase,
    input  size_t      op_zz,
    input  logic       ram_wait,
    output logic [1:0] dec_fetched,
    output phase_t     dec_phase,
    output size_t      dec_size,
    output logic       dec_size_we,
    output we_mask_t   dec_we,
    output we_mask_t   dec_keep_we,
    output logic       dec_keep_pc,
    output logic       dec_flag_we,
    output logic       dec_rfp_we,
    output logic       dec_inc_rfp,
    output logic       dec_dec_rfp,
    output logic       dec_nodummy,
    output alu_op_t    dec_alu_op,
    output logic       dec_alu_smux,
    output logic       dec_alu_wait,
    output dst_sel_t   dst_sel,
    output src_sel_t   src_sel,
    output logic [2:0] short_reg,
    output imm_act_t   imm_act
);

    function automatic we_mask_t size_mask(input size_t zz);
        return (zz == SZ_BYTE) ? 3'b001 : (zz == SZ_WORD) ? 3'b010 : 3'b100;
    endfunction

    logic [7:0] opc;
    logic [3:0] op_hi;
    size_t      ld_size;

    assign opc     = {op.fields.grp, op.fields.zz, op.fields.sel, op.fields.rrr};
    assign op_hi   = {op.fields.grp, op.fields.zz};
    assign ld_size = (op_hi == 4'h2) ? SZ_BYTE : (op_hi == 4'h3) ? SZ_WORD : SZ_LONG;

    always_comb begin
        dec_fetched  = 2'd0;
        dec_phase    = phase;
        dec_size     = op_zz;
        dec_size_we  = 1'b0;
        dec_we       = '0;
        dec_keep_we  = '0;
        dec_keep_pc  = 1'b0;
        dec_flag_we  = 1'b0;
        dec_rfp_we   = 1'b0;
        dec_inc_rfp  = 1'b0;
        dec_dec_rfp  = 1'b0;
        dec_nodummy  = 1'b0;
        dec_alu_op   = ALU_NOP;
        dec_alu_smux = 1'b0;
        dec_alu_wait = 1'b0;
        dst_sel      = DST_HOLD;
        src_sel      = SRC_HOLD;
        short_reg    = op.fields.rrr;
        imm_act      = IMM_HOLD;
        if (!ram_wait) begin
            case (phase)
                FETCH: begin
                    casez (opc)
                        8'b0000_0000: dec_fetched = 2'd1;  // NOP
                        8'b11??_1???, 8'b11??_0111: begin  // register prefix
                            dec_size    = op.fields.zz;
                            dec_size_we = 1'b1;
                            dst_sel     = op.fields.sel ? DST_SHORT : DST_BYTE1;
                            src_sel     = SRC_NEW_DST;
                            dec_fetched = op.fields.sel ? 2'd1 : 2'd2;
                            dec_phase   = EXEC;
                        end
                        8'b0001_0010: begin                // CCF
                            dec_flag_we = 1'b1;
                            dec_alu_op  = ALU_CCF;
                            dec_fetched = 2'd1;
                        end
                        8'b0001_0111: begin                // LDF #n
                            dec_rfp_we  = 1'b1;
                            imm_act     = IMM_LOAD_BYTE1;
                            dec_fetched = 2'd2;
                        end
                        8'b0010_0???, 8'b0011_0???, 8'b0100_0???: begin  // LD R,#
                            dec_size     = ld_size;
                            dec_size_we  = 1'b1;
                            dst_sel      = DST_SHORT;
                            imm_act      = IMM_LOAD_BYTE1;
                            dec_alu_op   = ALU_MOVE;
                            dec_alu_smux = 1'b1;
                            dec_fetched  = 2'd2;
                            if (ld_size == SZ_BYTE) begin
                                dec_we = size_mask(ld_size);
                            end else begin
                                dec_keep_we  = size_mask(ld_size);
                                dec_alu_wait = 1'b1;
                                dec_phase    = FILL_IMM;
                            end
                        end
                        8'b0001_101?: begin                // JP 16/24-bit
                            dec_size    = opc[0] ? SZ_JP24 : SZ_WORD;
                            dec_size_we = 1'b1;
                            imm_act     = IMM_LOAD_BYTE1;
                            dec_keep_pc = 1'b1;
                            dec_fetched = 2'd2;
                            dec_phase   = FILL_IMM;
                        end
                        8'b0000_1100: begin                // INCF
                            dec_inc_rfp = 1'b1;
                            dec_fetched = 2'd1;
                        end
                        8'b0000_1101: begin                // DECF
                            dec_dec_rfp = 1'b1;
                            dec_fetched = 2'd1;
                        end
                        default: ;                         // unknown, wait here
                    endcase
                end
                EXEC: begin
                    dec_phase = FETCH;
                    casez (opc)
                        8'b1000_1???: begin                // LD R,r
                            dst_sel     = DST_SHORT;
                            src_sel     = SRC_OLD_DST;
                            dec_alu_op  = ALU_MOVE;
                            dec_we      = size_mask(op_zz);
                            dec_fetched = 2'd1;
                        end
                        8'b1010_1???: begin                // LD r,#3
                            imm_act      = IMM_LOAD_RRR;
                            dec_alu_op   = ALU_MOVE;
                            dec_alu_smux = 1'b1;
                            dec_we       = size_mask(op_zz);
                            dec_fetched  = 2'd1;
                        end
                        8'b0000_0110, 8'b0001_001?: begin  // CPL, EXTS/EXTZ
                            dec_alu_op  = (opc == 8'h06) ? ALU_CPL :
                                          opc[0] ? ALU_EXTS : ALU_EXTZ;
                            dec_we      = size_mask(op_zz);
                            dec_fetched = 2'd1;
                        end
                        8'b0000_111?: begin                // BS1F/BS1B into A
                            dec_alu_op  = opc[0] ? ALU_BS1B : ALU_BS1F;
                            dst_sel     = DST_SHORT;
                            short_reg   = 3'd0;
                            dec_we      = size_mask(op_zz);
                            dec_fetched = 2'd1;
                        end
                        8'b0011_001?: begin                // CHG #4 / BIT #4
                            imm_act      = IMM_LOAD_NIBBLE;
                            dec_alu_op   = opc[0] ? ALU_BIT : ALU_CHG;
                            dec_alu_smux = 1'b1;
                            dec_flag_we  = opc[0];
                            dec_we       = opc[0] ? 3'b000 : size_mask(op_zz);
                            dec_fetched  = 2'd2;
                        end
                        8'b0000_0011, 8'b0011_1100, 8'b0011_1101, 8'b0011_1110: begin
                            dec_alu_op   = (opc == 8'h03) ? ALU_MOVE  :
                                           (opc == 8'h3c) ? ALU_MDEC1 :
                                           (opc == 8'h3d) ? ALU_MDEC2 : ALU_MDEC4;
                            imm_act      = IMM_LOAD_BYTE1;
                            dec_alu_smux = 1'b1;
                            dec_fetched  = 2'd2;
                            if (op_zz == SZ_BYTE) begin
                                dec_we = size_mask(op_zz);
                            end else begin
                                dec_keep_we  = size_mask(op_zz);
                                dec_alu_wait = 1'b1;
                                dec_phase    = FILL_IMM;
                            end
                        end
                        8'b100?_0???, 8'b1010_0???, 8'b1100_0???,
                        8'b1110_0???, 8'b1111_0???: begin  // ALU R,r
                            dec_alu_op  = (opc[7:3] == 5'b1000_0) ? ALU_ADD :
                                          (opc[7:3] == 5'b1001_0) ? ALU_ADC :
                                          (opc[7:3] == 5'b1010_0) ? ALU_SUB :
                                          (opc[7:3] == 5'b1100_0) ? ALU_AND :
                                          (opc[7:3] == 5'b1110_0) ? ALU_OR  : ALU_CP;
                            dst_sel     = DST_SHORT;
                            src_sel     = SRC_OLD_DST;
                            dec_flag_we = opc[7:3] == 5'b1111_0;
                            dec_keep_we = dec_flag_we ? 3'b000 : size_mask(op_zz);
                            dec_phase   = DUMMY;   // byte is taken in DUMMY
                        end
                        8'b1100_10??, 8'b1100_1100, 8'b1100_1110, 8'b1100_1111: begin
                            dec_alu_op   = (opc == 8'hc8) ? ALU_ADD :
                                           (opc == 8'hc9) ? ALU_ADC :
                                           (opc == 8'hca) ? ALU_SUB :
                                           (opc == 8'hcb) ? ALU_SBC :
                                           (opc == 8'hcc) ? ALU_AND :
                                           (opc == 8'hce) ? ALU_OR  : ALU_CP;
                            imm_act      = IMM_LOAD_BYTE1;
                            dec_alu_smux = 1'b1;
                            dec_flag_we  = opc == 8'hcf;  // CP only sets flags
                            dec_fetched  = 2'd2;
                            if (op_zz == SZ_BYTE) begin
                                dec_we      = dec_flag_we ? 3'b000 : size_mask(op_zz);
                                dec_nodummy = 1'b1;
                                dec_phase   = DUMMY;
                            end else begin
                                dec_keep_we  = dec_flag_we ? 3'b000 : size_mask(op_zz);
                                dec_alu_wait = 1'b1;
                                dec_phase    = FILL_IMM;
                            end
                        end
                        default: ;
                    endcase
                end
                FILL_IMM: begin
                    dec_phase   = FETCH;
                    dec_fetched = (op_zz == SZ_LONG) ? 2'd3 :
                                  (op_zz == SZ_JP24) ? 2'd2 : 2'd1;
                end
                DUMMY: begin
                    dec_phase   = FETCH;
                    dec_fetched = 2'd1;
                end
                default: dec_phase = FETCH;
            endcase
        end
    end

endmodule

//--- hdl/imm_builder.sv
// ALU immediate register
`timescale 1ns/1ps

module imm_builder import cpu_isa_pkg::*, ctrl_phase_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  op_word_u    op,
    input  imm_act_t    imm_act,
    input  logic        fill,
    input  size_t       op_zz,
    output logic [31:0] alu_imm
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_imm <= '0;
        end else if (cen) begin
            case (imm_act)
                IMM_LOAD_BYTE1:  alu_imm <= {24'd0, op.bytes[1]};
                IMM_LOAD_NIBBLE: alu_imm <= {28'd0, op.bytes[1][3:0]};  // bit number
                IMM_LOAD_RRR:    alu_imm <= {29'd0, op.bytes[0][2:0]};
                default: ;
            endcase
            // fill bytes sit at the start of the window
            if (fill) begin
                case (op_zz)
                    SZ_WORD: begin
                        alu_imm[31:16] <= '0;
                        alu_imm[15:8]  <= op.bytes[0];
                    end
                    SZ_LONG: alu_imm[31:8] <= {op.bytes[2], op.bytes[1], op.bytes[0]};
                    SZ_JP24: alu_imm[23:8] <= {op.bytes[1], op.bytes[0]};
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hdl/reg_select.sv
// Register code selection
`timescale 1ns/1ps

module reg_select import cpu_isa_pkg::*, ctrl_phase_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  op_word_u   op,
    input  dst_sel_t   dst_sel,
    input  src_sel_t   src_sel,
    input  logic [2:0] short_reg,
    input  size_t      op_zz,
    output reg_code_t  regs_dst,
    output reg_code_t  regs_src
);

    // byte fields pick a lane of the word register, others a whole register
    function automatic reg_code_t expand_reg(input logic [2:0] r, input size_t zz);
        if (zz == SZ_BYTE) begin
            return {REG_BASE_E, r[2:1], 1'b0, ~r[0]};
        end
        return r[2] ? {REG_BASE_F, r[1:0], 2'b00} : {REG_BASE_E, r[1:0], 2'b00};
    endfunction

    reg_code_t nx_dst;

    always_comb begin
        case (dst_sel)
            DST_SHORT: nx_dst = expand_reg(short_reg, op_zz);
            DST_BYTE1: nx_dst = op.bytes[1];   // extended prefix code
            default:   nx_dst = regs_dst;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs_dst <= '0;
            regs_src <= '0;
        end else if (cen) begin
            regs_dst <= nx_dst;
            case (src_sel)
                SRC_NEW_DST: regs_src <= nx_dst;
                SRC_OLD_DST: regs_src <= regs_dst;   // prefix register becomes source
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/cpu_ctrl_top.sv
// CPU instruction sequencer
`timescale 1ns/1ps

module cpu_ctrl_top import cpu_isa_pkg::*, ctrl_phase_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [31:0] op,
    input  logic        op_ok,
    output logic [1:0]  fetched,
    output logic        pc_we,
    output logic        inc_rfp,
    output logic        dec_rfp,
    output logic        rfp_we,
    output logic [31:0] alu_imm,
    output alu_op_t     alu_op,
    output logic        alu_smux,
    output logic        alu_wait,
    output logic        flag_we,
    output we_mask_t    regs_we,
    output reg_code_t   regs_dst,
    output reg_code_t   regs_src
);

    phase_t     phase;
    size_t      op_zz;
    logic       ram_wait;
    logic       fill;
    logic [1:0] dec_fetched;
    phase_t     dec_phase;
    size_t      dec_size;
    logic       dec_size_we;
    we_mask_t   dec_we;
    we_mask_t   dec_keep_we;
    logic       dec_keep_pc;
    logic       dec_flag_we;
    logic       dec_rfp_we;
    logic       dec_inc_rfp;
    logic       dec_dec_rfp;
    logic       dec_nodummy;
    alu_op_t    dec_alu_op;
    logic       dec_alu_smux;
    logic       dec_alu_wait;
    dst_sel_t   dst_sel;
    src_sel_t   src_sel;
    logic [2:0] short_reg;
    imm_act_t   imm_act;

    ctrl_fsm u_fsm (.*);

    op_decoder u_dec (.*);

    imm_builder u_imm (.*);

    // expansion uses the size that is current for this decode
    reg_select u_regs (.*, .op_zz(dec_size));

endmodule

//--- dv/cpu_ctrl_asserts.sv
// Sequencer output assertions
`timescale 1ns/1ps

module cpu_ctrl_asserts import ctrl_phase_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       cen,
    input logic       stall,
    input phase_t     phase,
    input logic [1:0] fetched,
    input we_mask_t   regs_we
);

    // refill cycle never takes bytes
    stall_no_fetch: assert property (@(posedge clk) disable iff (rst)
        (cen && stall) |-> (fetched == 2'd0))
        else $error("bytes consumed in a stall cycle");

    phase_legal: assert property (@(posedge clk) disable iff (rst)
        phase inside {FETCH, EXEC, FILL_IMM, DUMMY})
        else $error("phase holds an unused encoding");

    // at most one write size at a time
    write_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(regs_we))
        else $error("register write mask is not one-hot");

endmodule

//--- dv/cpu_ctrl_tb.sv
// Instruction sequencer testbench
`timescale 1ns/1ps

module cpu_ctrl_tb import cpu_isa_pkg::*, ctrl_phase_pkg::*; ();

    localparam int k_reg  = 0;   // expected strobe kinds
    localparam int k_pc   = 1;
    localparam int k_flag = 2;
    localparam int k_rfp  = 3;
    localparam int k_inc  = 4;
    localparam int k_dec  = 5;
    localparam int strobe_timeout = 200;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [31:0] op;
    logic        op_ok;
    logic [1:0]  fetched;
    logic        pc_we;
    logic        inc_rfp;
    logic        dec_rfp;
    logic        rfp_we;
    logic [31:0] alu_imm;
    alu_op_t     alu_op;
    logic        alu_smux;
    logic        alu_wait;
    logic        flag_we;
    we_mask_t    regs_we;
    reg_code_t   regs_dst;
    reg_code_t   regs_src;

    logic [7:0]  fifo[$];         // bytes not yet consumed
    int          drop;            // bytes taken at the coming rising edge
    int          seed;

    string       names[32];
    int          nbytes[32];
    logic [47:0] stream[32];      // first byte in the top used lane
    int          kind[32];
    alu_op_t     exp_op[32];
    logic        exp_smux[32];
    logic        exp_wait[32];    // alu_wait seen while the immediate fills
    we_mask_t    exp_we[32];
    reg_code_t   exp_dst[32];
    reg_code_t   exp_src[32];
    logic [31:0] exp_imm[32];
    int          n_tests;

    cpu_ctrl_top UUT (.*);

    bind ctrl_fsm cpu_ctrl_asserts u_asserts (
        .clk(clk),
        .rst(rst),
        .cen(cen),
        .stall(stall),
        .phase(phase),
        .fetched(fetched),
        .regs_we(regs_we)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("Error: %s %s expected %0h actual %0h", test, what, exp, act));
        end
    endtask

    task automatic add_test(input string nm, input int n, input logic [47:0] b, input int k,
                            input alu_op_t aop, input logic sm, input logic wt,
                            input we_mask_t we, input reg_code_t dst, input reg_code_t src,
                            input logic [31:0] imm);
        names[n_tests]    = nm;
        nbytes[n_tests]   = n;
        stream[n_tests]   = b;
        kind[n_tests]     = k;
        exp_op[n_tests]   = aop;
        exp_smux[n_tests] = sm;
        exp_wait[n_tests] = wt;
        exp_we[n_tests]   = we;
        exp_dst[n_tests]  = dst;
        exp_src[n_tests]  = src;
        exp_imm[n_tests]  = imm;
        n_tests++;
    endtask

    // name, length, bytes, strobe, alu op, smux, wait, write mask, dst, src, immediate
    task automatic build_table();
        add_test("ld_b", 2, 48'h235a, k_reg, ALU_MOVE, 1, 0, 1, 'he4, 'h00, 'h5a);
        add_test("ld_w", 3, 48'h353412, k_reg, ALU_MOVE, 1, 1, 2, 'hf4, 'h00, 'h1234);
        add_test("ld_l", 5, 48'h4678563412, k_reg, ALU_MOVE, 1, 1, 4, 'hf8, 'h00, 'h12345678);
        add_test("jp16", 3, 48'h1acdab, k_pc, ALU_NOP, 0, 0, 0, 'hf8, 'h00, 'habcd);
        add_test("jp24", 4, 48'h1b563412, k_pc, ALU_NOP, 0, 0, 0, 'hf8, 'h00, 'h123456);
        add_test("add_rr_w", 2, 48'hd982, k_reg, ALU_ADD, 0, 0, 2, 'he8, 'he4, 'h123456);
        add_test("sub_rr_x", 3, 48'hc7e0a3, k_reg, ALU_SUB, 0, 0, 1, 'he4, 'he0, 'h123456);
        add_test("and_rr_l", 2, 48'hecc5, k_reg, ALU_AND, 0, 0, 4, 'hf4, 'hf0, 'h123456);
        add_test("or_rr_w", 2, 48'hdae1, k_reg, ALU_OR, 0, 0, 2, 'he4, 'he8, 'h123456);
        add_test("ld_rr_w", 2, 48'hd98a, k_reg, ALU_MOVE, 0, 0, 2, 'he8, 'he4, 'h123456);
        add_test("cp_rr_b", 2, 48'hcaf0, k_flag, ALU_CP, 0, 0, 0, 'he1, 'he5, 'h123456);
        add_test("ccf", 1, 48'h12, k_flag, ALU_CCF, 0, 0, 0, 'he1, 'he5, 'h123456);
        add_test("add_i_b", 3, 48'hc9c811, k_reg, ALU_ADD, 1, 0, 1, 'he0, 'he0, 'h11);
        add_test("sbc_i_w", 4, 48'hdbcb2233, k_reg, ALU_SBC, 1, 1, 2, 'hec, 'hec, 'h3322);
        add_test("cp_i_b", 3, 48'hcccf05, k_flag, ALU_CP, 1, 0, 0, 'he9, 'he9, 'h05);
        add_test("ld_i_l", 6, 48'hef03efbeadde, k_reg, ALU_MOVE, 1, 1, 4, 'hfc, 'hfc,
                 'hdeadbeef);
        add_test("ld3_b", 2, 48'hc8ad, k_reg, ALU_MOVE, 1, 0, 1, 'he1, 'he1, 'h5);
        add_test("chg_w", 3, 48'hd8320b, k_reg, ALU_CHG, 1, 0, 2, 'he0, 'he0, 'hb);
        add_test("bit_b", 3, 48'hce3305, k_flag, ALU_BIT, 1, 0, 0, 'hed, 'hed, 'h5);
        add_test("cpl_b", 2, 48'hcb06, k_reg, ALU_CPL, 0, 0, 1, 'he4, 'he4, 'h5);
        add_test("extz_w", 2, 48'hdd12, k_reg, ALU_EXTZ, 0, 0, 2, 'hf4, 'hf4, 'h5);
        add_test("ldf", 2, 48'h1702, k_rfp, ALU_NOP, 0, 0, 0, 'hf4, 'hf4, 'h2);
        add_test("nop_incf", 2, 48'h000c, k_inc, ALU_NOP, 0, 0, 0, 'hf4, 'hf4, 'h2);
        add_test("decf", 1, 48'h0d, k_dec, ALU_NOP, 0, 0, 0, 'hf4, 'hf4, 'h2);
    endtask

    // next four bytes, zero padded past the end of the stream
    function automatic logic [31:0] window();
        logic [31:0] w;
        int i;
        w = '0;
        for (i = 0; i < 4; i++) begin
            if (i < fifo.size()) w[8*i +: 8] = fifo[i];
        end
        return w;
    endfunction

    // one clock cycle of the fetch source
    task automatic tick();
        int i;
        @(negedge clk);
        for (i = 0; i < drop; i++) begin
            if (fifo.size() == 0) fail_run("DUT consumed more bytes than were supplied");
            else void'(fifo.pop_front());
        end
        op_ok = (fifo.size() > 0) && ($urandom_range(3, 0) != 0);   // random refill gaps
        op    = window();
        #1;
        drop  = cen ? int'(fetched) : 0;
    endtask

    function automatic logic strobe_high(input int k);
        case (k)
            k_reg:   return regs_we != 3'b000;
            k_pc:    return pc_we;
            k_flag:  return flag_we;
            k_rfp:   return rfp_we;
            k_inc:   return inc_rfp;
            default: return dec_rfp;
        endcase
    endfunction

    task automatic run_test(input int idx);
        int j;
        int cycles;
        logic found;
        logic wait_seen;
        for (j = nbytes[idx] - 1; j >= 0; j--) begin
            fifo.push_back(stream[idx][8*j +: 8]);
        end
        found     = 1'b0;
        wait_seen = 1'b0;
        cycles    = 0;
        while (!found && cycles < strobe_timeout) begin
            tick();
            found = strobe_high(kind[idx]);
            if (!found && alu_wait) wait_seen = 1'b1;
            cycles++;
        end
        if (!found) fail_run($sformatf("timed out waiting for the strobe of test %s", names[idx]));
        check_value(names[idx], "alu_op", 32'(exp_op[idx]), 32'(alu_op));
        check_value(names[idx], "alu_smux", 32'(exp_smux[idx]), 32'(alu_smux));
        check_value(names[idx], "alu_wait", 32'(exp_wait[idx]), 32'(wait_seen));
        check_value(names[idx], "regs_we", 32'(exp_we[idx]), 32'(regs_we));
        check_value(names[idx], "regs_dst", 32'(exp_dst[idx]), 32'(regs_dst));
        check_value(names[idx], "regs_src", 32'(exp_src[idx]), 32'(regs_src));
        check_value(names[idx], "alu_imm", exp_imm[idx], alu_imm);
    endtask

    initial begin
        int idx;
        int cycles;
        rst          = 1'b1;
        cen          = 1'b1;
        op           = '0;
        op_ok        = 1'b0;
        drop         = 0;
        n_tests      = 0;
        seed         = $urandom(82278);
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        tick();
        check_value("reset", "strobes", 32'd0,
                    {23'd0, regs_we, pc_we, flag_we, rfp_we, inc_rfp, dec_rfp, alu_wait});
        check_value("reset", "alu_op", 32'(ALU_NOP), 32'(alu_op));
        for (idx = 0; idx < n_tests; idx++) begin
            run_test(idx);
        end
        cycles = 0;
        while ((fifo.size() != 0 || drop != 0) && cycles < strobe_timeout) begin
            tick();
            cycles++;
        end
        if (fifo.size() != 0) begin
            fail_run("byte stream was not fully consumed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- tb.f
hdl/cpu_isa_pkg.sv
hdl/ctrl_phase_pkg.sv
hdl/ctrl_fsm.sv
hdl/op_decoder.sv
hdl/imm_builder.sv
hdl/reg_select.sv
hdl/cpu_ctrl_top.sv
dv/cpu_ctrl_asserts.sv
dv/cpu_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= cpu_ctrl_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
